/* include/dbg_settings.svh */
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// probe widths from the processor core
`define DBG_PC_W 7
`define DBG_OPC_W 7

// value range shown in decimal, 20 bits fit six digits modulo one million
`define DBG_VAL_W 20

// pipeline stages with a pc and opcode probe
`define DBG_NUM_STAGES 7

// board resources
`define DBG_NUM_DIGITS 6
`define DBG_SW_W 10
`define DBG_LED_W 10

`endif

/* rtl/dbg_probe_pkg.sv */
`include "dbg_settings.svh"

package dbg_probe_pkg;

  // stage codes as set on the three low switches, code 7 is unused
  typedef enum logic [2:0] {
    stage_fetch       = 3'd0,
    stage_fetch_wait  = 3'd1,
    stage_decode      = 3'd2,
    stage_execute     = 3'd3,
    stage_memory      = 3'd4,
    stage_memory_wait = 3'd5,
    stage_writeback   = 3'd6
  } stage_sel_e;

  // switch layout, top bit first
  typedef struct packed {
    logic       manual_clk;
    logic       show_reg;
    logic [4:0] view_sel;
    stage_sel_e stage_sel;
  } board_sw_fields_t;

  // raw view for change detection, field view for decoding
  typedef union packed {
    logic [`DBG_SW_W-1:0] raw;
    board_sw_fields_t     f;
  } board_sw_u;

  // view_sel code for the flag view
  localparam logic [4:0] view_flags = 5'b10000;

  // status register bits 31 down to 28
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } status_flags_t;

endpackage

/* rtl/seg_display_pkg.sv */
package seg_display_pkg;

  // 0..9 decimal, 10..15 blank
  typedef logic [3:0] digit_t;

  // active low, segment g in bit 6
  typedef logic [6:0] seg_t;

  // digit position 0..5, 0 is least significant
  typedef logic [2:0] digit_idx_t;

  localparam seg_t seg_blank = 7'b1111111;

  function automatic seg_t encode_digit(input digit_t d);
    seg_t s;
    case (d)
      4'd0: s = 7'b1000000;
      4'd1: s = 7'b1111001;
      4'd2: s = 7'b0100100;
      4'd3: s = 7'b0110000;
      4'd4: s = 7'b0011001;
      4'd5: s = 7'b0010010;
      4'd6: s = 7'b0000010;
      4'd7: s = 7'b1111000;
      4'd8: s = 7'b0000000;
      4'd9: s = 7'b0010000;
      default: s = seg_blank;
    endcase
    return s;
  endfunction

endpackage

/* rtl/disp_digit_if.sv */
`timescale 1ns/1ns

interface disp_digit_if
  import seg_display_pkg::*;
();

  // pulse in the first cycle of every refresh
  logic       restart;
  logic       digit_we;
  digit_idx_t digit_idx;
  digit_t     digit_val;

  modport producer (
    output restart,
    output digit_we,
    output digit_idx,
    output digit_val
  );

  modport consumer (
    input restart,
    input digit_we,
    input digit_idx,
    input digit_val
  );

endinterface

/* rtl/stage_probe_select.sv */
`timescale 1ns/1ns
`include "dbg_settings.svh"

module stage_probe_select
  import dbg_probe_pkg::*;
(
  input  board_sw_u              sw,
  input  logic [`DBG_PC_W-1:0]   pc_fetch,
  input  logic [`DBG_PC_W-1:0]   pc_fetch_wait,
  input  logic [`DBG_PC_W-1:0]   pc_decode,
  input  logic [`DBG_PC_W-1:0]   pc_execute,
  input  logic [`DBG_PC_W-1:0]   pc_memory,
  input  logic [`DBG_PC_W-1:0]   pc_memory_wait,
  input  logic [`DBG_PC_W-1:0]   pc_writeback,
  input  logic [`DBG_OPC_W-1:0]  opc_fetch,
  input  logic [`DBG_OPC_W-1:0]  opc_fetch_wait,
  input  logic [`DBG_OPC_W-1:0]  opc_decode,
  input  logic [`DBG_OPC_W-1:0]  opc_execute,
  input  logic [`DBG_OPC_W-1:0]  opc_memory,
  input  logic [`DBG_OPC_W-1:0]  opc_memory_wait,
  input  logic [`DBG_OPC_W-1:0]  opc_writeback,
  output logic [`DBG_PC_W-1:0]   stage_pc,
  output logic [`DBG_LED_W-1:0]  led_pattern
);

  logic [`DBG_OPC_W-1:0] stage_opc;

  // pc of the chosen stage
  always_comb begin
    case (sw.f.stage_sel)
      stage_fetch:       stage_pc = pc_fetch;
      stage_fetch_wait:  stage_pc = pc_fetch_wait;
      stage_decode:      stage_pc = pc_decode;
      stage_execute:     stage_pc = pc_execute;
      stage_memory:      stage_pc = pc_memory;
      stage_memory_wait: stage_pc = pc_memory_wait;
      stage_writeback:   stage_pc = pc_writeback;
      default:           stage_pc = '0;
    endcase
  end

  // opcode of the chosen stage
  always_comb begin
    case (sw.f.stage_sel)
      stage_fetch:       stage_opc = opc_fetch;
      stage_fetch_wait:  stage_opc = opc_fetch_wait;
      stage_decode:      stage_opc = opc_decode;
      stage_execute:     stage_opc = opc_execute;
      stage_memory:      stage_opc = opc_memory;
      stage_memory_wait: stage_opc = opc_memory_wait;
      stage_writeback:   stage_opc = opc_writeback;
      default:           stage_opc = '0;
    endcase
  end

  // all ones in register view and the inverted opcode in stage view
  always_comb begin
    if (sw.f.show_reg) begin
      led_pattern = '1;
    end else begin
      led_pattern = {{(`DBG_LED_W - `DBG_OPC_W){1'b0}}, ~stage_opc};
    end
  end

endmodule

/* rtl/div10_stage.sv */
`timescale 1ns/1ns
`include "dbg_settings.svh"

module div10_stage
  import seg_display_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DBG_VAL_W-1:0]  load_val,
  input  logic                   load,
  output logic [`DBG_VAL_W-1:0]  quotient,
  output digit_t                 remainder
);

  localparam logic [`DBG_VAL_W-1:0] ten = `DBG_VAL_W'd10;

  // one divide step per cycle with the quotient fed back as the next input
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quotient <= '0;
    end else if (load) begin
      quotient <= load_val / ten;
    end
  end

  // digit of the current input in the same cycle
  assign remainder = digit_t'(load_val % ten);

endmodule

/* rtl/decimal_digit_engine.sv */
`timescale 1ns/1ns
`include "dbg_settings.svh"

module decimal_digit_engine
  import dbg_probe_pkg::*;
  import seg_display_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  board_sw_u              sw,
  input  logic [`DBG_PC_W-1:0]   stage_pc,
  input  logic [`DBG_VAL_W-1:0]  reg_value,
  input  status_flags_t          flags,
  disp_digit_if.producer         dig
);

  localparam digit_idx_t last_digit = digit_idx_t'(`DBG_NUM_DIGITS - 1);

  digit_idx_t            state_q;
  digit_idx_t            state_d;
  board_sw_u             sw_q;
  board_sw_u             cur_sw;
  logic                  sw_changed;
  logic                  flag_view;
  logic                  write_en;
  logic [2:0]            flag_q;
  logic                  flag_bit;
  logic [`DBG_VAL_W-1:0] src_val;
  logic [`DBG_VAL_W-1:0] div_in;
  logic [`DBG_VAL_W-1:0] quotient;
  digit_t                remainder;

  // a switch change mid-refresh abandons the rest of it
  assign sw_changed = (state_q != '0) && (sw.raw != sw_q.raw);

  // live switches in state 0 and the latched copy after it
  assign cur_sw    = (state_q == '0) ? sw : sw_q;
  assign flag_view = (cur_sw.f.view_sel == view_flags);

  assign src_val = cur_sw.f.show_reg ? reg_value
                                     : {{(`DBG_VAL_W - `DBG_PC_W){1'b0}}, stage_pc};

  // the source goes in first and each quotient after it
  assign div_in = (state_q == '0) ? src_val : quotient;

  div10_stage div_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_val  (div_in),
    .load      (write_en),
    .quotient  (quotient),
    .remainder (remainder)
  );

  always_comb begin
    if (sw_changed || state_q == last_digit) begin
      state_d = '0;
    end else begin
      state_d = state_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '0;
      sw_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == '0) begin
        sw_q <= sw;
      end
    end
  end

  // c z and n shift out behind the live v bit and zeros follow them
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_q <= '0;
    end else if (state_q == '0) begin
      flag_q <= {flags.n, flags.z, flags.c};
    end else begin
      flag_q <= {1'b0, flag_q[2:1]};
    end
  end

  assign flag_bit = (state_q == '0) ? flags.v : flag_q[0];

  // no write in the cycle that detects a switch change
  assign write_en = !sw_changed;

  assign dig.restart   = (state_q == '0);
  assign dig.digit_we  = write_en;
  assign dig.digit_idx = state_q;
  assign dig.digit_val = flag_view ? digit_t'({3'b000, flag_bit}) : remainder;

endmodule

/* rtl/seg_digit_bank.sv */
`timescale 1ns/1ns
`include "dbg_settings.svh"

module seg_digit_bank
  import seg_display_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           manual_clk,
  disp_digit_if.consumer dig,
  output seg_t           hex0,
  output seg_t           hex1,
  output seg_t           hex2,
  output seg_t           hex3,
  output seg_t           hex4,
  output seg_t           hex5
);

  seg_t seg_q [`DBG_NUM_DIGITS];
  logic synced_q;
  logic accept;

  // writes count only once a refresh has started from digit 0
  assign accept = dig.digit_we && (synced_q || dig.restart);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      synced_q <= 1'b0;
      for (int i = 0; i < `DBG_NUM_DIGITS; i++) begin
        seg_q[i] <= seg_blank;
      end
    end else begin
      if (dig.restart) begin
        synced_q <= 1'b1;
      end
      if (accept) begin
        seg_q[dig.digit_idx] <= encode_digit(dig.digit_val);
      end
    end
  end

  // display is dark unless the manual clock switch is on
  assign hex0 = manual_clk ? seg_q[0] : seg_blank;
  assign hex1 = manual_clk ? seg_q[1] : seg_blank;
  assign hex2 = manual_clk ? seg_q[2] : seg_blank;
  assign hex3 = manual_clk ? seg_q[3] : seg_blank;
  assign hex4 = manual_clk ? seg_q[4] : seg_blank;
  assign hex5 = manual_clk ? seg_q[5] : seg_blank;

endmodule

/* rtl/board_debug_top.sv */
`timescale 1ns/1ns
`include "dbg_settings.svh"

module board_debug_top
  import dbg_probe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DBG_PC_W-1:0]   pc_fetch,
  input  logic [`DBG_PC_W-1:0]   pc_fetch_wait,
  input  logic [`DBG_PC_W-1:0]   pc_decode,
  input  logic [`DBG_PC_W-1:0]   pc_execute,
  input  logic [`DBG_PC_W-1:0]   pc_memory,
  input  logic [`DBG_PC_W-1:0]   pc_memory_wait,
  input  logic [`DBG_PC_W-1:0]   pc_writeback,
  input  logic [`DBG_OPC_W-1:0]  opc_fetch,
  input  logic [`DBG_OPC_W-1:0]  opc_fetch_wait,
  input  logic [`DBG_OPC_W-1:0]  opc_decode,
  input  logic [`DBG_OPC_W-1:0]  opc_execute,
  input  logic [`DBG_OPC_W-1:0]  opc_memory,
  input  logic [`DBG_OPC_W-1:0]  opc_memory_wait,
  input  logic [`DBG_OPC_W-1:0]  opc_writeback,
  input  logic [31:0]            selected_register,
  input  logic [31:0]            status_register,
  input  logic [`DBG_SW_W-1:0]   sw,
  output logic [6:0]             hex0,
  output logic [6:0]             hex1,
  output logic [6:0]             hex2,
  output logic [6:0]             hex3,
  output logic [6:0]             hex4,
  output logic [6:0]             hex5,
  output logic [`DBG_LED_W-1:0]  ledr
);

  board_sw_u             sw_u;
  status_flags_t         flags;
  logic [`DBG_VAL_W-1:0] reg_value;
  logic [`DBG_PC_W-1:0]  stage_pc;
  logic [`DBG_LED_W-1:0] led_pattern;

  assign sw_u      = board_sw_u'(sw);
  // n z c v sit in the top nibble of the status register
  assign flags     = status_flags_t'(status_register[31:28]);
  assign reg_value = selected_register[`DBG_VAL_W-1:0];

  // leds dark outside manual clock mode, like the digits
  assign ledr = sw_u.f.manual_clk ? led_pattern : '1;

  disp_digit_if dig_if ();

  stage_probe_select probe_sel_i (
    .sw              (sw_u),
    .pc_fetch        (pc_fetch),
    .pc_fetch_wait   (pc_fetch_wait),
    .pc_decode       (pc_decode),
    .pc_execute      (pc_execute),
    .pc_memory       (pc_memory),
    .pc_memory_wait  (pc_memory_wait),
    .pc_writeback    (pc_writeback),
    .opc_fetch       (opc_fetch),
    .opc_fetch_wait  (opc_fetch_wait),
    .opc_decode      (opc_decode),
    .opc_execute     (opc_execute),
    .opc_memory      (opc_memory),
    .opc_memory_wait (opc_memory_wait),
    .opc_writeback   (opc_writeback),
    .stage_pc        (stage_pc),
    .led_pattern     (led_pattern)
  );

  decimal_digit_engine engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .sw        (sw_u),
    .stage_pc  (stage_pc),
    .reg_value (reg_value),
    .flags     (flags),
    .dig       (dig_if.producer)
  );

  seg_digit_bank bank_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .manual_clk (sw_u.f.manual_clk),
    .dig        (dig_if.consumer),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5)
  );

endmodule

/* dv/board_debug_tb.sv */
`timescale 1ns/1ns
`include "dbg_settings.svh"

module board_debug_tb
  import dbg_probe_pkg::*;
  import seg_display_pkg::*;
();

  typedef struct {
    logic [`DBG_SW_W-1:0] sw;
    logic                 rnd;
    logic                 glitch;
    logic [6:0]           base;
    logic [31:0]          reg_val;
    logic [31:0]          status;
  } row_t;

  localparam logic [4:0] v_stage = 5'b00000;
  localparam logic [4:0] v_flag  = 5'b10000;

  logic                  clk;
  logic                  rst_n;
  logic [`DBG_PC_W-1:0]  pc_v [`DBG_NUM_STAGES];
  logic [`DBG_OPC_W-1:0] opc_v [`DBG_NUM_STAGES];
  logic [31:0]           sel_reg;
  logic [31:0]           status;
  logic [`DBG_SW_W-1:0]  sw_v;
  seg_t                  hex_o [`DBG_NUM_DIGITS];
  logic [`DBG_LED_W-1:0] ledr;

  row_t        rows [$];
  logic [31:0] lfsr;
  int          checks = 0;
  int          errors = 0;
  int          row_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  board_debug_top dut_i (
    .clk (clk), .rst_n (rst_n),
    .pc_fetch (pc_v[0]), .pc_fetch_wait (pc_v[1]), .pc_decode (pc_v[2]),
    .pc_execute (pc_v[3]), .pc_memory (pc_v[4]), .pc_memory_wait (pc_v[5]),
    .pc_writeback (pc_v[6]),
    .opc_fetch (opc_v[0]), .opc_fetch_wait (opc_v[1]), .opc_decode (opc_v[2]),
    .opc_execute (opc_v[3]), .opc_memory (opc_v[4]), .opc_memory_wait (opc_v[5]),
    .opc_writeback (opc_v[6]),
    .selected_register (sel_reg), .status_register (status), .sw (sw_v),
    .hex0 (hex_o[0]), .hex1 (hex_o[1]), .hex2 (hex_o[2]),
    .hex3 (hex_o[3]), .hex4 (hex_o[4]), .hex5 (hex_o[5]),
    .ledr (ledr)
  );

  always #20 clk = ~clk;

  // runaway guard
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [`DBG_SW_W-1:0] make_sw(input logic manual, input logic show,
                                                    input logic [4:0] view,
                                                    input logic [2:0] stage);
    board_sw_u u;
    u.f.manual_clk = manual;
    u.f.show_reg   = show;
    u.f.view_sel   = view;
    u.f.stage_sel  = stage_sel_e'(stage);
    return u.raw;
  endfunction

  // active low, g in bit 6
  function automatic seg_t digit_pattern(input int d);
    case (d)
      0: return 7'b1000000;
      1: return 7'b1111001;
      2: return 7'b0100100;
      3: return 7'b0110000;
      4: return 7'b0011001;
      5: return 7'b0010010;
      6: return 7'b0000010;
      7: return 7'b1111000;
      8: return 7'b0000000;
      9: return 7'b0010000;
      default: return 7'b1111111;
    endcase
  endfunction

  task automatic check_seg(input string name, input seg_t got, input seg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errors++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_led(input string name, input logic [`DBG_LED_W-1:0] got,
                           input logic [`DBG_LED_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errors++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input logic [`DBG_SW_W-1:0] sw, input logic rnd, input logic glitch,
                         input logic [6:0] base, input logic [31:0] reg_val,
                         input logic [31:0] st);
    row_t r;
    r.sw      = sw;
    r.rnd     = rnd;
    r.glitch  = glitch;
    r.base    = base;
    r.reg_val = reg_val;
    r.status  = st;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // all zero first, then each stage code including the unused one
    add_row(make_sw(1'b1, 1'b0, v_stage, 3'd0), 1'b0, 1'b0, 7'h00, 32'h0, 32'h0);
    for (int s = 0; s < 8; s++) begin
      add_row(make_sw(1'b1, 1'b0, v_stage, 3'(s)), 1'b0, 1'b0, 7'h35, 32'h0, 32'h0);
    end
    add_row(make_sw(1'b1, 1'b1, v_stage, 3'd2), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b1, v_stage, 3'd5), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b1, v_stage, 3'd0), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b1, v_stage, 3'd6), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b0, v_flag, 3'd1), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b0, v_flag, 3'd4), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b1, v_flag, 3'd3), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b0, v_flag, 3'd7), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    // display dark
    add_row(make_sw(1'b0, 1'b0, v_stage, 3'd3), 1'b0, 1'b0, 7'h5b, 32'h0, 32'h0);
    add_row(make_sw(1'b0, 1'b0, v_flag, 3'd2), 1'b1, 1'b0, 7'h00, 32'h0, 32'h0);
    // switches flip shortly before the final setting
    add_row(make_sw(1'b1, 1'b0, v_stage, 3'd4), 1'b0, 1'b1, 7'h2f, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b1, v_stage, 3'd1), 1'b1, 1'b1, 7'h00, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b0, v_flag, 3'd5), 1'b1, 1'b1, 7'h00, 32'h0, 32'h0);
    // edge values
    add_row(make_sw(1'b1, 1'b0, v_stage, 3'd0), 1'b0, 1'b0, 7'h7f, 32'h0, 32'h0);
    add_row(make_sw(1'b1, 1'b1, v_stage, 3'd0), 1'b0, 1'b0, 7'h00, 32'habcfffff, 32'h0);
    add_row(make_sw(1'b1, 1'b0, v_flag, 3'd6), 1'b0, 1'b0, 7'h11, 32'h0, 32'hf0000000);
    add_row(make_sw(1'b1, 1'b0, v_flag, 3'd0), 1'b0, 1'b0, 7'h11, 32'h0, 32'h50000000);
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0] bits;
    for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
      if (r.rnd) begin
        draw_bits(7, bits);
        pc_v[s] = bits[6:0];
        draw_bits(7, bits);
        opc_v[s] = bits[6:0];
      end else begin
        pc_v[s]  = r.base * 7'(s + 1);
        opc_v[s] = r.base * 7'(s + 5);
      end
    end
    if (r.rnd) begin
      draw_bits(32, bits);
      sel_reg = bits;
      draw_bits(32, bits);
      status = bits;
    end else begin
      sel_reg = r.reg_val;
      status  = r.status;
    end
    if (r.glitch) begin
      // show_reg and the flag view bit toggled for a few cycles
      sw_v = r.sw ^ 10'h180;
      repeat (3) @(negedge clk);
    end
    sw_v = r.sw;
    repeat (16) @(negedge clk);
  endtask

  task automatic check_outputs();
    seg_t                  exp_hex [`DBG_NUM_DIGITS];
    logic [`DBG_LED_W-1:0] exp_led;
    logic [6:0]            pc;
    logic [6:0]            opc;
    board_sw_u             u;
    int                    val;
    u.raw = sw_v;
    pc    = (u.raw[2:0] == 3'd7) ? 7'd0 : pc_v[u.raw[2:0]];
    opc   = (u.raw[2:0] == 3'd7) ? 7'd0 : opc_v[u.raw[2:0]];
    if (u.f.view_sel == v_flag) begin
      // v, c, z, n from status bits 28 to 31
      for (int k = 0; k < `DBG_NUM_DIGITS; k++) begin
        exp_hex[k] = digit_pattern((k < 4) ? int'(status[28 + k]) : 0);
      end
    end else begin
      val = u.f.show_reg ? int'(sel_reg[19:0]) : int'(pc);
      for (int k = 0; k < `DBG_NUM_DIGITS; k++) begin
        exp_hex[k] = digit_pattern(val % 10);
        val = val / 10;
      end
    end
    if (!u.f.manual_clk || u.f.show_reg) begin
      exp_led = '1;
    end else begin
      exp_led = {3'b000, ~opc};
    end
    for (int k = 0; k < `DBG_NUM_DIGITS; k++) begin
      check_seg($sformatf("hex%0d", k), hex_o[k],
                u.f.manual_clk ? exp_hex[k] : 7'b1111111);
    end
    check_led("ledr", ledr, exp_led);
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    sw_v    = make_sw(1'b1, 1'b0, v_stage, 3'd0);
    sel_reg = '0;
    status  = '0;
    for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
      pc_v[s]  = '0;
      opc_v[s] = '0;
    end
    lfsr = 32'ha7af8ccd;
    build_table();
    cycle_limit = 16 + rows.size() * 16 + 64;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    // nothing refreshed yet
    for (int k = 0; k < `DBG_NUM_DIGITS; k++) begin
      check_seg($sformatf("hex%0d", k), hex_o[k], 7'b1111111);
    end
    $display("reset blank check: %0d errors", row_errors);
    for (int i = 0; i < rows.size(); i++) begin
      row_errors = 0;
      apply_row(rows[i]);
      check_outputs();
      $display("row %0d sw=%b: %0d errors", i, rows[i].sw, row_errors);
    end
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
rtl/dbg_probe_pkg.sv
rtl/seg_display_pkg.sv
rtl/disp_digit_if.sv
rtl/stage_probe_select.sv
rtl/div10_stage.sv
rtl/decimal_digit_engine.sv
rtl/seg_digit_bank.sv
rtl/board_debug_top.sv
dv/board_debug_tb.sv

/* Makefile */
TOP = board_debug_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module board_debug_top

clean:
	rm -rf obj_dir
